// ==== fetch_top.f ====
verilog/fetch_pkg.sv
verilog/ifetch.sv
verilog/icache.sv
verilog/fetch_top.sv
sim/tb_clock.sv
sim/fetch_checker.sv
sim/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  # synthesizable fetch front end
  - files:
      - verilog/fetch_pkg.sv
      - verilog/ifetch.sv
      - verilog/icache.sv
      - verilog/fetch_top.sv

  # testbench, top module tb_fetch_top
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/fetch_checker.sv
      - sim/tb_fetch_top.sv

// ==== sim/tb_fetch_top.sv ====
`timescale 1ns/100ps

module tb_fetch_top
  import fetch_pkg::*;
();

  localparam int         ADDR_WIDTH  = 32;
  localparam int         CACHE_LINES = 8;
  localparam int         MEM_LATENCY = 3;
  localparam int         MAX_CYCLES  = 4000;
  localparam int         DRIVE_DELAY = 2;
  localparam int         LOOP_LINES  = 4;
  localparam inst_word_t LOOP_START  = 32'h0000_4000;
  localparam inst_word_t CONFLICT_A  = 32'h0000_1000;
  localparam inst_word_t CONFLICT_B  = CONFLICT_A + CACHE_LINES * 16;  // same index.

  logic                  clock;
  logic                  reset_n;
  logic                  stall;
  logic                  load_pc;
  inst_word_t            new_pc;
  inst_word_t            inst_word0, inst_word1, inst_word2, inst_word3;
  logic                  inst_valid0, inst_valid1, inst_valid2, inst_valid3;
  inst_word_t            pc_out0, pc_out1, pc_out2, pc_out3;
  logic                  branch_stall;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic                  mem_rd;
  fetch_line_t           mem_data;
  logic                  mem_valid;
  logic [2:0]            phase;
  int                    error_count;
  int                    slot_count;
  int                    phase_count;
  int                    cycle_count;
  inst_word_t            lcg_state;
  inst_word_t            req_addr;

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clock (.clock, .reset_n);

  fetch_top #(.ADDR_WIDTH(ADDR_WIDTH), .CACHE_LINES(CACHE_LINES)) DUT (
    .clock, .reset_n, .stall, .load_pc, .new_pc,
    .inst_word0, .inst_word1, .inst_word2, .inst_word3,
    .inst_valid0, .inst_valid1, .inst_valid2, .inst_valid3,
    .pc_out0, .pc_out1, .pc_out2, .pc_out3,
    .branch_stall, .mem_addr, .mem_rd, .mem_data, .mem_valid
  );

  fetch_checker #(.LOOP_LINES(LOOP_LINES)) u_checker (
    .clock, .reset_n, .stall, .load_pc, .new_pc,
    .inst_word0, .inst_word1, .inst_word2, .inst_word3,
    .inst_valid0, .inst_valid1, .inst_valid2, .inst_valid3,
    .pc_out0, .pc_out1, .pc_out2, .pc_out3,
    .branch_stall, .mem_addr, .mem_rd,
    .phase, .error_count, .slot_count, .phase_count
  );

  function automatic inst_word_t word_at(input inst_word_t addr);
    return addr ^ 32'h3c5a96e1;
  endfunction

  function automatic inst_word_t lcg_next(input inst_word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ##########################################################################
  // memory model returning one line per read after a fixed latency
  // ##########################################################################

  initial begin
    mem_valid = 1'b0;
    mem_data  = '0;
    forever begin
      @(negedge clock);
      if (mem_rd) begin
        req_addr = inst_word_t'(mem_addr);
        repeat (MEM_LATENCY) @(posedge clock);
        #DRIVE_DELAY;
        mem_valid = 1'b1;
        mem_data  = {word_at(req_addr), word_at(req_addr + 32'd4),
                     word_at(req_addr + 32'd8), word_at(req_addr + 32'd12)};
        @(posedge clock);
        #DRIVE_DELAY;
        mem_valid = 1'b0;
      end
    end
  end

  // counts accepted cycles while misses just wait.
  task automatic fetch_lines(input int count);
    int done;
    done    = 0;
    stall   = 1'b0;
    load_pc = 1'b0;
    while (done < count) begin
      @(negedge clock);
      if (!branch_stall) done++;
      @(posedge clock);
      #DRIVE_DELAY;
    end
  endtask

  task automatic redirect(input inst_word_t addr);
    logic taken;
    taken   = 1'b0;
    stall   = 1'b0;
    load_pc = 1'b1;
    new_pc  = addr;
    while (!taken) begin
      @(negedge clock);
      taken = !branch_stall;  // held until the cache hits.
      @(posedge clock);
      #DRIVE_DELAY;
    end
    load_pc = 1'b0;
  endtask

  task automatic random_stall(input int cycles);
    load_pc = 1'b0;
    for (int k = 0; k < cycles; k++) begin
      lcg_state = lcg_next(lcg_state);
      stall     = (lcg_state[31:29] < 3'd3);  // about 3 in 8.
      @(posedge clock);
      #DRIVE_DELAY;
    end
    stall = 1'b0;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    stall     = 1'b0;
    load_pc   = 1'b0;
    new_pc    = '0;
    phase     = 3'd0;
    lcg_state = 32'h9236687d;
    @(posedge reset_n);
    @(posedge clock);
    #DRIVE_DELAY;
    phase = 3'd1;
    fetch_lines(12);
    phase = 3'd2;
    redirect(32'h0000_0104);
    fetch_lines(3);
    redirect(32'h0000_0228);
    fetch_lines(3);
    redirect(32'h0000_030c);
    fetch_lines(3);
    phase = 3'd3;
    random_stall(200);
    phase = 3'd4;
    redirect(LOOP_START);
    fetch_lines(LOOP_LINES - 1);
    redirect(LOOP_START);  // leaves from the last loop line.
    phase = 3'd5;
    fetch_lines(LOOP_LINES - 1);
    redirect(CONFLICT_A);
    phase = 3'd6;
    for (int r = 0; r < 3; r++) begin
      fetch_lines(1);
      redirect(CONFLICT_B);
      fetch_lines(1);
      redirect(CONFLICT_A);
    end
    fetch_lines(2);
    phase = 3'd7;
    repeat (2) @(posedge clock);
    $display("tests %0d, slots checked %0d, errors %0d", phase_count, slot_count, error_count);
    if (error_count == 0 && phase_count == 6) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/fetch_checker.sv ====
`timescale 1ns/100ps

module fetch_checker
  import fetch_pkg::*;
#(
  parameter int LOOP_LINES = 4
) (
  input  logic       clock,
  input  logic       reset_n,
  input  logic       stall,
  input  logic       load_pc,
  input  inst_word_t new_pc,
  input  inst_word_t inst_word0,
  input  inst_word_t inst_word1,
  input  inst_word_t inst_word2,
  input  inst_word_t inst_word3,
  input  logic       inst_valid0,
  input  logic       inst_valid1,
  input  logic       inst_valid2,
  input  logic       inst_valid3,
  input  inst_word_t pc_out0,
  input  inst_word_t pc_out1,
  input  inst_word_t pc_out2,
  input  inst_word_t pc_out3,
  input  logic       branch_stall,
  input  inst_word_t mem_addr,
  input  logic       mem_rd,
  input  logic [2:0] phase,
  output int         error_count,
  output int         slot_count,
  output int         phase_count
);

  inst_word_t word_s [WORDS_PER_LINE];
  inst_word_t addr_s [WORDS_PER_LINE];
  logic [3:0] valid_s;
  logic       prev_stall;
  logic       prev_bs;
  logic       prev_load;
  logic       prev_rd;
  inst_word_t prev_new_pc;
  inst_word_t expect_addr;  // next instruction address due.
  inst_word_t miss_line;
  logic [2:0] last_phase;
  int         phase_err;
  int         phase_groups;
  int         phase_bs;
  int         phase_rises;

  function automatic inst_word_t expected_word(input inst_word_t addr);
    return addr ^ 32'h3c5a96e1;
  endfunction

  // empty or one run that reaches slot 3.
  function automatic logic run_ok(input logic [3:0] v);
    return (v == 4'b0000) || (v == 4'b1000) || (v == 4'b1100) ||
           (v == 4'b1110) || (v == 4'b1111);
  endfunction

  function automatic string phase_name(input logic [2:0] p);
    case (p)
      3'd1:    return "sequential fetch";
      3'd2:    return "misaligned redirect";
      3'd3:    return "random stall";
      3'd4:    return "loop first pass";
      3'd5:    return "loop second pass";
      default: return "conflict eviction";
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    error_count++;
    phase_err++;
  endtask

  task automatic close_phase(input logic [2:0] p);
    if (p == 3'd4 && phase_rises < LOOP_LINES) begin
      report_error($sformatf("only %0d misses on the first loop pass", phase_rises));
    end
    if (p == 3'd5 && phase_bs != 0) begin
      report_error($sformatf("%0d branch_stall cycles on the cached loop pass", phase_bs));
    end
    $display("phase %0d, %s: %0d groups, %0d branch_stall cycles, %0d errors",
             p, phase_name(p), phase_groups, phase_bs, phase_err);
    phase_count++;
  endtask

  // ##########################################################################
  // sampled mid cycle while outputs show the previous cycle's fetch
  // ##########################################################################

  always @(negedge clock) begin
    if (!reset_n) begin
      error_count = 0;
      slot_count  = 0;
      phase_count = 0;
      prev_stall  = 1'b1;  // no fetch before reset ends.
      prev_bs     = 1'b1;
      prev_load   = 1'b0;
      prev_rd     = 1'b0;
      prev_new_pc = '0;
      expect_addr = '0;
      last_phase  = 3'd0;
    end else begin
      word_s[0] = inst_word0;
      word_s[1] = inst_word1;
      word_s[2] = inst_word2;
      word_s[3] = inst_word3;
      addr_s[0] = pc_out0;
      addr_s[1] = pc_out1;
      addr_s[2] = pc_out2;
      addr_s[3] = pc_out3;
      valid_s   = {inst_valid3, inst_valid2, inst_valid1, inst_valid0};
      if (phase != last_phase) begin
        if (last_phase != 3'd0) begin
          close_phase(last_phase);
        end
        phase_err    = 0;
        phase_groups = 0;
        phase_bs     = 0;
        phase_rises  = 0;
        last_phase   = phase;
      end
      if (branch_stall) phase_bs++;
      if (branch_stall && !prev_bs) phase_rises++;
      // a fill reads the line of the next address due.
      miss_line = {expect_addr[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
      if (mem_rd && prev_rd) begin
        report_error("mem_rd held high for more than one cycle");
      end
      if (mem_rd && mem_addr != miss_line) begin
        report_error($sformatf("mem_addr %h, expected %h", mem_addr, miss_line));
      end
      if (!run_ok(valid_s)) begin
        report_error($sformatf("valid slots %b are not a run ending at slot 3", valid_s));
      end
      if ((prev_stall || prev_bs || prev_load) && valid_s != 4'b0000) begin
        report_error("valid slots after a stall, miss or redirect cycle");
      end
      if (!prev_stall && !prev_bs && !prev_load && valid_s == 4'b0000) begin
        report_error("accepted fetch gave no valid slot");
      end
      // first group after a redirect starts at new_pc's own slot.
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
        if (valid_s[i]) begin
          if (addr_s[i] != expect_addr) begin
            report_error($sformatf("slot %0d pc_out %h, expected %h", i, addr_s[i], expect_addr));
          end else if (word_s[i] != expected_word(addr_s[i])) begin
            report_error($sformatf("slot %0d word %h at %h, expected %h", i, word_s[i],
                                   addr_s[i], expected_word(addr_s[i])));
          end
          expect_addr = expect_addr + 32'd4;
          slot_count++;
        end
      end
      if (valid_s != 4'b0000) phase_groups++;
      if (prev_load && !prev_stall && !prev_bs) begin
        expect_addr = {prev_new_pc[31:2], 2'b00};
        if (phase == 3'd6 && !branch_stall) begin
          report_error("return to an evicted line did not miss");
        end
      end
      prev_stall  = stall;
      prev_bs     = branch_stall;
      prev_load   = load_pc;
      prev_rd     = mem_rd;
      prev_new_pc = new_pc;
    end
  end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // release just after a rising edge.
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2 reset_n = 1'b1;
  end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top
  import fetch_pkg::*;
#(
  parameter int ADDR_WIDTH  = 32,
  parameter int CACHE_LINES = 8
) (
  input  logic                  clock,
  input  logic                  reset_n,

  input  logic                  stall,
  input  logic                  load_pc,
  input  inst_word_t            new_pc,

  output inst_word_t            inst_word0,
  output inst_word_t            inst_word1,
  output inst_word_t            inst_word2,
  output inst_word_t            inst_word3,
  output logic                  inst_valid0,
  output logic                  inst_valid1,
  output logic                  inst_valid2,
  output logic                  inst_valid3,
  output inst_word_t            pc_out0,
  output inst_word_t            pc_out1,
  output inst_word_t            pc_out2,
  output inst_word_t            pc_out3,
  output logic                  branch_stall,

  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic                  mem_rd,
  input  fetch_line_t           mem_data,
  input  logic                  mem_valid
);

  logic [ADDR_WIDTH-1:0] cache_addr;
  fetch_line_t           cache_data;
  logic                  cache_waitrequest;

  ifetch #(.ADDR_WIDTH(ADDR_WIDTH)) u_ifetch (
    .clock, .reset_n,
    .cache_addr, .cache_data, .cache_waitrequest,
    .stall, .load_pc, .new_pc,
    .inst_word0, .inst_word1, .inst_word2, .inst_word3,
    .inst_valid0, .inst_valid1, .inst_valid2, .inst_valid3,
    .pc_out0, .pc_out1, .pc_out2, .pc_out3,
    .branch_stall
  );

  // hits answer in the same cycle.
  icache #(.ADDR_WIDTH(ADDR_WIDTH), .CACHE_LINES(CACHE_LINES)) u_icache (
    .clock, .reset_n,
    .cache_addr, .cache_data, .cache_waitrequest,
    .mem_addr, .mem_rd, .mem_data, .mem_valid
  );

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/100ps

module icache
  import fetch_pkg::*;
#(
  parameter int ADDR_WIDTH  = 32,
  parameter int CACHE_LINES = 8
) (
  input  logic                  clock,
  input  logic                  reset_n,

  input  logic [ADDR_WIDTH-1:0] cache_addr,
  output fetch_line_t           cache_data,
  output logic                  cache_waitrequest,

  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic                  mem_rd,
  input  fetch_line_t           mem_data,
  input  logic                  mem_valid
);

  localparam int INDEX_BITS = $clog2(CACHE_LINES);
  localparam int TAG_LSB    = LINE_OFFSET_BITS + INDEX_BITS;

  cache_state_t           state;

  logic [CACHE_LINES-1:0] line_valid;
  line_tag_t              tag_mem  [CACHE_LINES];
  fetch_line_t            data_mem [CACHE_LINES];

  logic [INDEX_BITS-1:0]  rd_index;
  line_tag_t              rd_tag;
  logic                   hit;

  logic [INDEX_BITS-1:0]  fill_index;
  line_tag_t              fill_tag;
  logic                   fill_done;
  logic                   miss_now;

  // #########################################################################
  // lookup
  // #########################################################################

  assign rd_index = cache_addr[LINE_OFFSET_BITS +: INDEX_BITS];
  assign rd_tag   = line_tag_t'(cache_addr[ADDR_WIDTH-1:TAG_LSB]);
  assign hit      = line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);

  assign cache_data        = data_mem[rd_index];
  assign cache_waitrequest = (state != cache_lookup) || !hit;

  assign miss_now = (state == cache_lookup) && !hit;

  // #########################################################################
  // fill state machine
  // #########################################################################

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state  <= cache_lookup;
      mem_rd <= 1'b0;
    end else begin
      mem_rd <= 1'b0;
      case (state)
        cache_lookup: begin
          if (!hit) begin
            state  <= cache_fill_req;
            mem_rd <= 1'b1;  // single pulse.
          end
        end
        cache_fill_req: begin
          state <= cache_fill_wait;
        end
        cache_fill_wait: begin
          if (mem_valid) begin
            state <= cache_lookup;
          end
        end
        default: begin
          state <= cache_lookup;
        end
      endcase
    end
  end

  // line address of the pending fill.
  always_ff @(posedge clock) begin
    if (miss_now) begin
      mem_addr <= {cache_addr[ADDR_WIDTH-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    end
  end

  assign fill_index = mem_addr[LINE_OFFSET_BITS +: INDEX_BITS];
  assign fill_tag   = line_tag_t'(mem_addr[ADDR_WIDTH-1:TAG_LSB]);
  assign fill_done  = (state == cache_fill_wait) && mem_valid;

  // #########################################################################
  // line storage
  // #########################################################################

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      line_valid <= '0;
    end else if (fill_done) begin
      line_valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_done) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= mem_data;  // replaces the old line.
    end
  end

  // read strobe only right after a miss.
  a_rd_in_req: assert property (@(posedge clock) disable iff (!reset_n)
    mem_rd |-> (state == cache_fill_req));

  // memory answers only a fill in flight.
  a_valid_in_wait: assert property (@(posedge clock) disable iff (!reset_n)
    mem_valid |-> (state == cache_fill_wait));

endmodule

// ==== verilog/ifetch.sv ====
`timescale 1ns/100ps

module ifetch
  import fetch_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clock,
  input  logic                  reset_n,

  output logic [ADDR_WIDTH-1:0] cache_addr,
  input  fetch_line_t           cache_data,
  input  logic                  cache_waitrequest,

  input  logic                  stall,
  input  logic                  load_pc,
  input  inst_word_t            new_pc,

  output inst_word_t            inst_word0,
  output inst_word_t            inst_word1,
  output inst_word_t            inst_word2,
  output inst_word_t            inst_word3,

  output logic                  inst_valid0,
  output logic                  inst_valid1,
  output logic                  inst_valid2,
  output logic                  inst_valid3,

  output inst_word_t            pc_out0,
  output inst_word_t            pc_out1,
  output inst_word_t            pc_out2,
  output inst_word_t            pc_out3,

  output logic                  branch_stall
);

  localparam int SLOT_BITS  = $clog2(WORDS_PER_LINE);
  localparam int LINE_BYTES = WORDS_PER_LINE * 4;

  inst_word_t                pc;
  logic [SLOT_BITS-1:0]      slot_idx;
  inst_word_t                align_step;
  inst_word_t                line_base;
  logic                      pc_move;     // pc may change this cycle.
  logic                      fetch_ok;    // accepted fetch.

  inst_word_t                slot_word [WORDS_PER_LINE];
  inst_word_t                slot_addr [WORDS_PER_LINE];
  logic [WORDS_PER_LINE-1:0] slot_valid;

  inst_word_t                word_r    [WORDS_PER_LINE];
  inst_word_t                addr_r    [WORDS_PER_LINE];
  logic [WORDS_PER_LINE-1:0] valid_r;

  // #########################################################################
  // program counter
  // #########################################################################

  assign pc_move  = !stall && !cache_waitrequest;
  assign fetch_ok = pc_move && !load_pc;

  assign slot_idx   = pc[LINE_OFFSET_BITS-1:2];
  assign line_base  = {pc[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
  assign align_step = inst_word_t'(LINE_BYTES) - inst_word_t'({slot_idx, 2'b00});

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= '0;
    end else if (pc_move) begin
      if (load_pc) begin
        pc <= {new_pc[31:2], 2'b00};  // word aligned.
      end else begin
        pc <= pc + align_step;        // on to the next line.
      end
    end
  end

  assign cache_addr   = pc[ADDR_WIDTH-1:0];
  assign branch_stall = cache_waitrequest;

  // #########################################################################
  // slot split and output registers
  // #########################################################################

  always_comb begin
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      slot_word[i]  = cache_waitrequest ? '0 : cache_data[(WORDS_PER_LINE-1-i)*32 +: 32];
      slot_addr[i]  = line_base + inst_word_t'(i * 4);
      slot_valid[i] = fetch_ok && (int'(slot_idx) <= i);  // from pc's slot on.
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_r <= '0;
    end else begin
      valid_r <= slot_valid;
    end
  end

  always_ff @(posedge clock) begin
    word_r <= slot_word;
    addr_r <= slot_addr;
  end

  assign inst_word0  = word_r[0];
  assign inst_word1  = word_r[1];
  assign inst_word2  = word_r[2];
  assign inst_word3  = word_r[3];

  assign inst_valid0 = valid_r[0];
  assign inst_valid1 = valid_r[1];
  assign inst_valid2 = valid_r[2];
  assign inst_valid3 = valid_r[3];

  assign pc_out0     = addr_r[0];
  assign pc_out1     = addr_r[1];
  assign pc_out2     = addr_r[2];
  assign pc_out3     = addr_r[3];

  // valid slots are one run that reaches the last slot.
  a_valid_run: assert property (@(posedge clock) disable iff (!reset_n)
    valid_r inside {4'b0000, 4'b1000, 4'b1100, 4'b1110, 4'b1111});

  // a stalled cycle yields an empty group.
  a_stall_empty: assert property (@(posedge clock) disable iff (!reset_n)
    stall |=> (valid_r == '0));

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // #########################################################################
  // instruction and line formats
  // #########################################################################

  localparam int WORDS_PER_LINE   = 4;  // instruction slots per line.
  localparam int LINE_OFFSET_BITS = 4;  // byte offset inside a line.

  // instruction word, also used for instruction addresses.
  typedef logic [31:0] inst_word_t;

  // four words, lowest address in the top bits.
  typedef logic [WORDS_PER_LINE*32-1:0] fetch_line_t;

  // tag storage, wide enough for any tag of a 32-bit address.
  // narrower tags are zero extended.
  typedef logic [$bits(inst_word_t)-LINE_OFFSET_BITS-1:0] line_tag_t;

  // #########################################################################
  // icache fill control
  // #########################################################################

  typedef enum logic [1:0] {
    cache_lookup,     // serving hits.
    cache_fill_req,   // read request out.
    cache_fill_wait   // waiting for the line.
  } cache_state_t;

endpackage
